/* dab_power_stage.f */
+incdir+include
logic/pwm_map_pkg.sv
logic/dab_ctrl_pkg.sv
logic/dab_setpoint_calc.sv
logic/dab_operating_core.sv
logic/pwm_register_file.sv
logic/pwm_chain.sv
logic/dab_power_stage.sv
test/dab_power_stage_tb.sv

/* logic/dab_ctrl_pkg.sv */
// DAB converter control types for modulation, setpoints and register writes
package dab_ctrl_pkg;

    typedef enum logic [1:0] {
        single_phase = 2'd0,
        dual_phase = 2'd1,
        triple_phase = 2'd2
    } modulation_t;

    typedef struct packed {
        logic [31:0] dest;
        logic [15:0] data;
    } reg_write_t;

    // Phase shifts are in counter ticks and may be negative
    typedef struct packed {
        logic [15:0] period;
        logic [15:0] duty_1;
        logic [15:0] duty_2;
        logic signed [15:0] phase_shift_1;
        logic signed [15:0] phase_shift_2;
    } setpoint_t;

endpackage

/* logic/dab_operating_core.sv */
// DAB operating core sequencing PWM register writes for start, update and stop
`timescale 1ns/1ps

module dab_operating_core #(
    parameter logic [31:0] pwm_base_addr = 32'h0,
    parameter int n_chains = 2
) (
    input logic clock,
    input logic reset,
    input logic start,
    input logic stop,
    input logic update,
    input dab_ctrl_pkg::setpoint_t setpoint,
    input dab_ctrl_pkg::modulation_t modulation,
    output dab_ctrl_pkg::reg_write_t write,
    output logic write_valid,
    input logic write_ready,
    output logic [15:0] echo_data,
    output logic echo_valid,
    output logic modulator_status,
    output logic busy
);

    localparam int chain_bits = (n_chains > 1) ? $clog2(n_chains) : 1;

    typedef enum logic [2:0] {
        idle,
        capture,
        period,
        phase,
        compare,
        control_on,
        control_off
    } state_t;

    state_t state;
    logic [chain_bits-1:0] chain_cnt;
    logic [1:0] compare_cnt;
    logic start_needed;
    logic stop_pending;
    logic take_setpoint;
    logic transfer;
    logic last_chain;
    logic [31:0] chain_base;
    pwm_map_pkg::pwm_regs_t chain_regs [n_chains];

    assign transfer = write_valid && write_ready;
    assign last_chain = chain_cnt == chain_bits'(n_chains - 1);
    assign take_setpoint = state == idle && !stop_pending &&
                           (start || (update && modulator_status));

    dab_setpoint_calc #(
        .n_chains(n_chains)
    ) dab_setpoint_calc_i (
        .clock(clock),
        .reset(reset),
        .capture(take_setpoint),
        .setpoint(setpoint),
        .modulation(modulation),
        .chain_regs(chain_regs)
    );

    ////////////////////////////////////////
    // Write address and data
    ////////////////////////////////////////

    // Held constant by the state and counters until the write is taken
    assign chain_base = pwm_base_addr + (32'(chain_cnt) + 32'd1) * pwm_map_pkg::chain_stride;

    always_comb begin
        write = '0;
        case (state)
            period: begin
                write.dest = chain_base + pwm_map_pkg::period_offset(n_chains);
                write.data = chain_regs[chain_cnt].period;
            end
            phase: begin
                write.dest = chain_base + pwm_map_pkg::phase_offset(n_chains);
                write.data = chain_regs[chain_cnt].phase;
            end
            compare: begin
                write.dest = chain_base + pwm_map_pkg::compare_offset_base +
                             32'(compare_cnt) * 32'd4;
                write.data = chain_regs[chain_cnt].compare[compare_cnt];
            end
            control_on: begin
                write.dest = pwm_base_addr + pwm_map_pkg::control_offset;
                write.data = pwm_map_pkg::control_on_word;
            end
            control_off: begin
                write.dest = pwm_base_addr + pwm_map_pkg::control_offset;
                write.data = 16'h0;
            end
            default: begin
            end
        endcase
    end

    assign echo_data = write.data;
    assign echo_valid = transfer && state == compare;
    assign busy = state != idle;

    ////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle;
            write_valid <= 1'b0;
            chain_cnt <= '0;
            compare_cnt <= '0;
            start_needed <= 1'b0;
            stop_pending <= 1'b0;
            modulator_status <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (stop_pending) begin
                        stop_pending <= 1'b0;
                        write_valid <= 1'b1;
                        state <= control_off;
                    end else if (take_setpoint) begin
                        start_needed <= start;
                        state <= capture;
                    end
                end
                capture: begin
                    write_valid <= 1'b1;
                    state <= period;
                end
                period, phase: begin
                    if (transfer) begin
                        chain_cnt <= last_chain ? '0 : chain_cnt + 1'b1;
                        if (last_chain) begin
                            state <= (state == period) ? phase : compare;
                        end
                    end
                end
                compare: begin
                    if (transfer) begin
                        compare_cnt <= compare_cnt + 1'b1;
                        if (compare_cnt == 2'd3) begin
                            chain_cnt <= last_chain ? '0 : chain_cnt + 1'b1;
                            if (last_chain) begin
                                state <= start_needed ? control_on : idle;
                                write_valid <= start_needed;
                            end
                        end
                    end
                end
                control_on, control_off: begin
                    if (transfer) begin
                        modulator_status <= state == control_on;
                        write_valid <= 1'b0;
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
            // A stop is kept until the sequencer is back in idle
            if (stop) begin
                stop_pending <= 1'b1;
            end
        end
    end

    assert property (@(posedge clock) disable iff (!reset)
        write_valid && !write_ready |=> write_valid && $stable(write));

    assert property (@(posedge clock) disable iff (!reset)
        write_valid |-> state inside {period, phase, compare, control_on, control_off});

endmodule

/* logic/dab_power_stage.sv */
// DAB power stage top joining the operating core, register file and PWM chains
`timescale 1ns/1ps

module dab_power_stage #(
    parameter logic [31:0] pwm_base_addr = 32'h0,
    parameter int n_chains = 2
) (
    input logic clock,
    input logic reset,
    input logic start,
    input logic stop,
    input logic update,
    input dab_ctrl_pkg::setpoint_t setpoint,
    input dab_ctrl_pkg::modulation_t modulation,
    output logic [4*n_chains-1:0] pwm_out,
    output logic modulator_status,
    output logic busy,
    output logic [15:0] echo_data,
    output logic echo_valid
);

    dab_ctrl_pkg::reg_write_t write;
    logic write_valid;
    logic write_ready;
    logic enable;
    logic period_end [n_chains];
    pwm_map_pkg::pwm_regs_t active_regs [n_chains];

    dab_operating_core #(
        .pwm_base_addr(pwm_base_addr),
        .n_chains(n_chains)
    ) dab_operating_core_i (
        .clock(clock),
        .reset(reset),
        .start(start),
        .stop(stop),
        .update(update),
        .setpoint(setpoint),
        .modulation(modulation),
        .write(write),
        .write_valid(write_valid),
        .write_ready(write_ready),
        .echo_data(echo_data),
        .echo_valid(echo_valid),
        .modulator_status(modulator_status),
        .busy(busy)
    );

    pwm_register_file #(
        .pwm_base_addr(pwm_base_addr),
        .n_chains(n_chains)
    ) pwm_register_file_i (
        .clock(clock),
        .reset(reset),
        .write(write),
        .write_valid(write_valid),
        .write_ready(write_ready),
        .period_end(period_end),
        .active_regs(active_regs),
        .enable(enable)
    );

    for (genvar k = 0; k < n_chains; k++) begin : g_chain
        pwm_chain pwm_chain_i (
            .clock(clock),
            .reset(reset),
            .enable(enable),
            .regs(active_regs[k]),
            .period_end(period_end[k]),
            .pwm_out(pwm_out[4*k +: 4])
        );
    end

endmodule

/* logic/dab_setpoint_calc.sv */
// DAB setpoint calculation producing per-chain period, phase and compare values
`timescale 1ns/1ps

module dab_setpoint_calc #(
    parameter int n_chains = 2
) (
    input logic clock,
    input logic reset,
    input logic capture,
    input dab_ctrl_pkg::setpoint_t setpoint,
    input dab_ctrl_pkg::modulation_t modulation,
    output pwm_map_pkg::pwm_regs_t chain_regs [n_chains]
);

    logic signed [17:0] p_full;
    logic signed [17:0] half_p;
    logic signed [17:0] quarter_p;
    logic signed [17:0] three_quarter_p;
    logic signed [17:0] ps1;
    logic signed [17:0] inner;
    logic signed [17:0] phase_1;
    logic signed [17:0] compare [4];
    logic captured;

    assign p_full = 18'(setpoint.period);
    assign half_p = p_full >>> 1;
    assign quarter_p = p_full >>> 2;
    assign three_quarter_p = 18'((3 * p_full) >>> 2);
    assign ps1 = 18'(setpoint.phase_shift_1);

    // Inner shift moves both legs of a chain apart symmetrically
    assign inner = (modulation != dab_ctrl_pkg::single_phase) ?
                   18'(setpoint.phase_shift_2 / 16'sd2) : 18'sd0;

    assign compare[0] = quarter_p - inner;
    assign compare[1] = quarter_p + inner;
    assign compare[2] = three_quarter_p - inner;
    assign compare[3] = three_quarter_p + inner;

    // Outer shift saturates at half a period either way
    always_comb begin
        if (ps1 > half_p) begin
            phase_1 = p_full;
        end else if (ps1 < -half_p) begin
            phase_1 = '0;
        end else if (modulation == dab_ctrl_pkg::triple_phase) begin
            phase_1 = half_p + 18'(setpoint.duty_2);
        end else begin
            phase_1 = half_p + ps1;
        end
    end

    always_ff @(posedge clock) begin
        if (capture) begin
            for (int k = 0; k < n_chains; k++) begin
                chain_regs[k].period <= setpoint.period;
                chain_regs[k].phase <= (k % 2 == 1) ? phase_1[15:0] : 16'h0;
                for (int c = 0; c < 4; c++) begin
                    chain_regs[k].compare[c] <= compare[c][15:0];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            captured <= 1'b0;
        end else if (capture) begin
            captured <= 1'b1;
        end
    end

    function automatic logic compares_in_period(input pwm_map_pkg::pwm_regs_t r);
        return r.compare[0] < r.period && r.compare[1] < r.period &&
               r.compare[2] < r.period && r.compare[3] < r.period;
    endfunction

    for (genvar k = 0; k < n_chains; k++) begin : g_check
        assert property (@(posedge clock) disable iff (!reset)
            captured |-> compares_in_period(chain_regs[k]));
    end

endmodule

/* logic/pwm_chain.sv */
// PWM chain with phase-shifted period counter and four compare outputs
`timescale 1ns/1ps

module pwm_chain (
    input logic clock,
    input logic reset,
    input logic enable,
    input pwm_map_pkg::pwm_regs_t regs,
    output logic period_end,
    output logic [3:0] pwm_out
);

    logic enable_d;
    logic running;
    logic leg_a;
    logic leg_b;
    logic [15:0] count;
    logic [15:0] start_value;

    assign running = enable && enable_d;
    assign period_end = running && count >= regs.period - 16'd1;

    // A phase of a full period is the same as no phase
    assign start_value = (regs.phase >= regs.period) ? 16'h0 : regs.phase;

    assign leg_a = count >= regs.compare[0] && count < regs.compare[2];
    assign leg_b = count >= regs.compare[1] && count < regs.compare[3];

    always_ff @(posedge clock) begin
        if (!reset) begin
            enable_d <= 1'b0;
            count <= '0;
        end else begin
            enable_d <= enable;
            if (enable && !enable_d) begin
                count <= start_value;
            end else if (period_end) begin
                count <= '0;
            end else if (running) begin
                count <= count + 16'd1;
            end
        end
    end

    // Registered outputs keep the bridge gates free of decode glitches
    always_ff @(posedge clock) begin
        if (!reset) begin
            pwm_out <= '0;
        end else if (running) begin
            pwm_out <= {!leg_b, !leg_a, leg_b, leg_a};
        end else begin
            pwm_out <= '0;
        end
    end

endmodule

/* logic/pwm_map_pkg.sv */
// PWM generator register map with register offsets, chain stride and control word
package pwm_map_pkg;

    // Control register sits at the generator base, outside every chain block
    localparam logic [31:0] control_offset = 32'h0;
    localparam logic [15:0] control_on_word = 16'h28;

    // Four compare registers per chain at offsets 0, 4, 8 and 12
    localparam logic [31:0] compare_offset_base = 32'h0;

    // Chain k is based at (k + 1) * chain_stride
    localparam logic [31:0] chain_stride = 32'h100;

    function automatic logic [31:0] period_offset(input int n);
        return 32'((3 * n + 1) * 4);
    endfunction

    function automatic logic [31:0] phase_offset(input int n);
        return 32'((3 * n + 2) * 4);
    endfunction

    typedef struct packed {
        logic [15:0] period;
        logic [15:0] phase;
        logic [3:0][15:0] compare;
    } pwm_regs_t;

endpackage

/* logic/pwm_register_file.sv */
// PWM register file with shadow registers copied to active at each period end
`timescale 1ns/1ps

module pwm_register_file #(
    parameter logic [31:0] pwm_base_addr = 32'h0,
    parameter int n_chains = 2
) (
    input logic clock,
    input logic reset,
    input dab_ctrl_pkg::reg_write_t write,
    input logic write_valid,
    output logic write_ready,
    input logic period_end [n_chains],
    output pwm_map_pkg::pwm_regs_t active_regs [n_chains],
    output logic enable
);

    pwm_map_pkg::pwm_regs_t shadow_regs [n_chains];
    logic [31:0] rel_addr;
    logic [31:0] block;
    logic [31:0] offset;
    logic any_period_end;
    logic accept;

    assign rel_addr = write.dest - pwm_base_addr;
    assign block = rel_addr / pwm_map_pkg::chain_stride;
    assign offset = rel_addr % pwm_map_pkg::chain_stride;

    always_comb begin
        any_period_end = 1'b0;
        for (int k = 0; k < n_chains; k++) begin
            any_period_end = any_period_end | period_end[k];
        end
    end

    // Writes wait out the cycle in which shadow is copied to active
    assign write_ready = !any_period_end;
    assign accept = write_valid && write_ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            enable <= 1'b0;
        end else if (accept && rel_addr == pwm_map_pkg::control_offset) begin
            enable <= write.data == pwm_map_pkg::control_on_word;
        end
    end

    always_ff @(posedge clock) begin
        for (int k = 0; k < n_chains; k++) begin
            if (accept && block == 32'(k + 1)) begin
                if (offset == pwm_map_pkg::period_offset(n_chains)) begin
                    shadow_regs[k].period <= write.data;
                end
                if (offset == pwm_map_pkg::phase_offset(n_chains)) begin
                    shadow_regs[k].phase <= write.data;
                end
                for (int c = 0; c < 4; c++) begin
                    if (offset == pwm_map_pkg::compare_offset_base + 32'(4 * c)) begin
                        shadow_regs[k].compare[c] <= write.data;
                    end
                end
            end
            // Stopped chains follow the shadow copy so a start sees fresh values
            if (period_end[k] || !enable) begin
                active_regs[k] <= shadow_regs[k];
            end
        end
    end

    function automatic logic known_register(input logic [31:0] blk, input logic [31:0] off);
        logic in_chain;
        in_chain = blk >= 32'd1 && blk <= 32'(n_chains);
        if (blk == 32'd0) begin
            return off == pwm_map_pkg::control_offset;
        end
        return in_chain && (off == pwm_map_pkg::period_offset(n_chains) ||
                            off == pwm_map_pkg::phase_offset(n_chains) ||
                            (off >= pwm_map_pkg::compare_offset_base &&
                             off < pwm_map_pkg::compare_offset_base + 32'd16 &&
                             off[1:0] == 2'b00));
    endfunction

    assert property (@(posedge clock) disable iff (!reset)
        accept |-> known_register(block, offset));

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module dab_power_stage_tb \
    -f dab_power_stage.f \
    -o dab_power_stage_sim

./obj_dir/dab_power_stage_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "TEST OK" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

/* include/dab_tb_tasks.svh */
// DAB power stage test tasks and reference model of the setpoint calculation
`ifndef DAB_TB_TASKS_SVH
`define DAB_TB_TASKS_SVH

function automatic logic [3:0][15:0] model_compare(input logic [15:0] period,
                                                   input logic signed [15:0] ps2,
                                                   input dab_ctrl_pkg::modulation_t mode);
    int s;
    int p;
    p = period;
    s = (mode == dab_ctrl_pkg::single_phase) ? 0 : ps2 / 2;
    model_compare[0] = 16'(p / 4 - s);
    model_compare[1] = 16'(p / 4 + s);
    model_compare[2] = 16'((3 * p) / 4 - s);
    model_compare[3] = 16'((3 * p) / 4 + s);
endfunction

function automatic logic [15:0] model_phase(input logic [15:0] period,
                                            input logic [15:0] duty_2,
                                            input logic signed [15:0] ps1,
                                            input dab_ctrl_pkg::modulation_t mode);
    int half;
    half = period / 2;
    if (ps1 > half) return period;
    if (ps1 < -half) return 16'h0;
    if (mode == dab_ctrl_pkg::triple_phase) return 16'(half + duty_2);
    return 16'(half + ps1);
endfunction

// High time and first rising edge of two outputs over one window
task automatic measure_pair(input int idx_a, input int idx_b, input int cycles,
                            output int high [2], output int rise [2]);
    logic [1:0] prev;
    prev = {pwm_out[idx_b], pwm_out[idx_a]};
    high = '{0, 0};
    rise = '{-1, -1};
    for (int i = 0; i < cycles; i++) begin
        @(negedge clock);
        for (int j = 0; j < 2; j++) begin
            if (pwm_out[j == 0 ? idx_a : idx_b]) high[j]++;
            if (pwm_out[j == 0 ? idx_a : idx_b] && !prev[j] && rise[j] < 0) rise[j] = i;
        end
        prev = {pwm_out[idx_b], pwm_out[idx_a]};
    end
endtask

`endif

/* test/dab_power_stage_tb.sv */
// DAB power stage testbench running directed start, update, clamp and stop sequences
`timescale 1ns/1ps

module dab_power_stage_tb;

    localparam int max_period = 62;
    localparam int test_count = 6;
    // Twenty of the longest periods per test, plus room for reset and the write sequences
    localparam int watchdog_cycles = test_count * 20 * max_period + 500;

    logic clock;
    logic reset;
    logic start;
    logic stop;
    logic update;
    dab_ctrl_pkg::setpoint_t setpoint;
    dab_ctrl_pkg::modulation_t modulation;
    logic [7:0] pwm_out;
    logic modulator_status;
    logic busy;
    logic [15:0] echo_data;
    logic echo_valid;

    integer seed;
    dab_ctrl_pkg::setpoint_t op_sp;
    dab_ctrl_pkg::modulation_t op_mode;

    dab_power_stage #(
        .pwm_base_addr(32'h0),
        .n_chains(2)
    ) dab_power_stage_i (
        .clock(clock),
        .reset(reset),
        .start(start),
        .stop(stop),
        .update(update),
        .setpoint(setpoint),
        .modulation(modulation),
        .pwm_out(pwm_out),
        .modulator_status(modulator_status),
        .busy(busy),
        .echo_data(echo_data),
        .echo_valid(echo_valid)
    );

    `include "dab_tb_tasks.svh"

    ////////////////////////////////////////
    // Clock and watchdog
    ////////////////////////////////////////

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        report_failure("Timeout: the tests did not finish within the watchdog limit");
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got == expected)
            else report_failure($sformatf("Fail %s: got %h expected %h", name, got, expected));
    endtask

    // One request line is held high across a single rising edge
    task automatic issue_request(input logic start_req, input logic stop_req,
                                 input logic update_req);
        @(negedge clock);
        start = start_req;
        stop = stop_req;
        update = update_req;
        @(negedge clock);
        start = 1'b0;
        stop = 1'b0;
        update = 1'b0;
    endtask

    task automatic follow_sequence(input logic [3:0][15:0] expected, output int words);
        words = 0;
        while (busy) begin
            if (echo_valid) begin
                check_value($sformatf("echo_data word %0d", words), echo_data,
                            expected[words % 4]);
                words++;
            end
            @(negedge clock);
        end
    endtask

    task automatic program_modulator(input logic is_start);
        int words;
        setpoint = op_sp;
        modulation = op_mode;
        issue_request(is_start, 1'b0, !is_start);
        follow_sequence(model_compare(op_sp.period, op_sp.phase_shift_2, op_mode), words);
        check_value("echo word count", words, 8);
        check_value("modulator_status", modulator_status, 1);
    endtask

    task automatic stop_modulator();
        issue_request(1'b0, 1'b1, 1'b0);
        while (!busy) @(negedge clock);
        while (busy) begin
            check_value("echo_valid", echo_valid, 0);
            @(negedge clock);
        end
        check_value("modulator_status", modulator_status, 0);
        @(negedge clock);
        check_value("pwm_out", pwm_out, 0);
    endtask

    // Chain lag and leg timing once the new values are active
    task automatic check_waveform();
        logic [3:0][15:0] cmp;
        int p;
        int phase;
        int lag;
        int high [2];
        int rise [2];
        p = op_sp.period;
        cmp = model_compare(op_sp.period, op_sp.phase_shift_2, op_mode);
        phase = model_phase(op_sp.period, op_sp.duty_2, op_sp.phase_shift_1, op_mode);
        repeat (2 * p) @(negedge clock);
        measure_pair(0, 4, p, high, rise);
        check_value("chain 0 bit 0 high time", high[0], int'(cmp[2]) - int'(cmp[0]));
        check_value("chain 1 bit 0 high time", high[1], int'(cmp[2]) - int'(cmp[0]));
        assert (rise[0] >= 0 && rise[1] >= 0)
            else report_failure("Bit 0 of a chain did not rise within one period");
        lag = (rise[1] - rise[0] + p) % p;
        check_value("chain 1 lag", lag, (p - phase) % p);
        measure_pair(0, 1, p, high, rise);
        check_value("chain 0 bit 1 high time", high[1], int'(cmp[3]) - int'(cmp[1]));
        lag = (rise[1] - rise[0] + p) % p;
        check_value("chain 0 bit 1 lag", lag, (int'(cmp[1]) - int'(cmp[0]) + p) % p);
        check_value("chain 0 bits 3:2", pwm_out[3:2], 2'(~pwm_out[1:0]));
        check_value("chain 1 bits 7:6", pwm_out[7:6], 2'(~pwm_out[5:4]));
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic idle_after_reset();
        repeat (10) begin
            @(negedge clock);
            check_value("pwm_out", pwm_out, 0);
            check_value("modulator_status", modulator_status, 0);
            check_value("busy", busy, 0);
            check_value("echo_valid", echo_valid, 0);
            check_value("write_valid", dab_power_stage_i.write_valid, 0);
        end
    endtask

    task automatic start_single_phase();
        int p;
        p = 32 + 2 * ({$random(seed)} % 16);
        op_sp = '0;
        op_sp.period = 16'(p);
        op_sp.duty_1 = 16'(p / 2);
        op_sp.duty_2 = 16'(p / 4);
        op_sp.phase_shift_1 = 16'(int'({$random(seed)} % (p / 2 + 1)) - p / 4);
        op_mode = dab_ctrl_pkg::single_phase;
        program_modulator(1'b1);
    endtask

    task automatic update_dual_phase();
        int p;
        p = op_sp.period;
        op_sp.phase_shift_2 = 16'(2 * (1 + {$random(seed)} % (p / 8)));
        op_mode = dab_ctrl_pkg::dual_phase;
        program_modulator(1'b0);
        check_waveform();
    endtask

    // Phase shifts beyond half a period saturate, high first and then low
    task automatic clamped_phase_lag();
        stop_modulator();
        op_sp.phase_shift_1 = 16'(int'(op_sp.period) / 2 + 5);
        program_modulator(1'b1);
        check_waveform();
        stop_modulator();
        op_mode = dab_ctrl_pkg::triple_phase;
        op_sp.phase_shift_1 = 16'(-(int'(op_sp.period) / 2) - 5);
        program_modulator(1'b1);
        check_waveform();
    endtask

    task automatic stop_and_ignore_update();
        stop_modulator();
        issue_request(1'b0, 1'b0, 1'b1);
        repeat (10) begin
            check_value("busy", busy, 0);
            check_value("echo_valid", echo_valid, 0);
            @(negedge clock);
        end
        check_value("modulator_status", modulator_status, 0);
    endtask

    initial begin
        seed = 32'h764d;
        reset = 1'b0;
        start = 1'b0;
        stop = 1'b0;
        update = 1'b0;
        setpoint = '0;
        modulation = dab_ctrl_pkg::single_phase;
        op_sp = '0;
        op_mode = dab_ctrl_pkg::single_phase;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;

        idle_after_reset();
        start_single_phase();
        check_waveform();
        update_dual_phase();
        clamped_phase_lag();
        stop_and_ignore_update();

        $display("TEST OK");
        $finish;
    end

endmodule
